// ==== Bender.yml ====
package:
  name: phold_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/phold_pkg.sv
      - source/history_fifo.sv
      - source/history_port.sv
      - source/history_filter.sv
      - source/event_sequencer.sv
      - source/phold_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/phold_core_asserts.sv
      - verification/phold_core_tb.sv

// ==== include/phold_params.svh ====
`ifndef PHOLD_PARAMS_SVH
`define PHOLD_PARAMS_SVH

// lp id and timestamp widths
`define PHOLD_LPID_W 3
`define PHOLD_TIME_W 16

// random word from the outside generator
`define PHOLD_RND_W 24

`define PHOLD_MSG_W 32
`define PHOLD_HIST_W 32

// sixteen history slots per lp
`define PHOLD_HIST_DEPTH_W 4
`define PHOLD_HIST_ADDR_W 8
`define PHOLD_OFFSET_W 8

// smallest time step from an event to the event it spawns
`define PHOLD_MIN_GAP 10

// fields taken from the random word
`define PHOLD_RND_STAMP_W 6
`define PHOLD_RND_TARGET_LSB 8
`define PHOLD_RND_DELAY_LSB 16
`define PHOLD_RND_DELAY_W 4

`endif

// ==== source/event_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "phold_params.svh"

module event_sequencer (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   event_valid,
   input  phold_pkg::event_msg_t  event_in,
   input  phold_pkg::sim_time_t   global_time,
   input  phold_pkg::rnd_t        random_in,
   input  logic                   stall,
   output logic                   ready,
   output logic                   start_read,
   output logic                   start_write,
   output phold_pkg::hist_cnt_t   length,
   input  logic                   done,
   output phold_pkg::event_msg_t  cur,
   output phold_pkg::sim_time_t   gvt,
   input  logic                   discard_cur,
   input  logic                   cancel_valid,
   input  phold_pkg::event_msg_t  cancel_msg,
   input  phold_pkg::hist_cnt_t   hist_count,
   output logic                   gen_wr,
   output phold_pkg::hist_entry_t gen_entry,
   input  logic                   rbk_empty,
   input  phold_pkg::hist_entry_t rbk_entry,
   output logic                   rbk_pop,
   output logic                   clear,
   output logic                   new_event_ready,
   output phold_pkg::event_msg_t  out_msg,
   input  logic                   ack
);

   localparam phold_pkg::event_msg_t null_msg = '{pad:       '0,
                                                  is_cancel: 1'b1,
                                                  target:    '0,
                                                  stamp:     '0};

   phold_pkg::core_state_t  state;
   phold_pkg::rnd_t         rnd;
   logic [`PHOLD_RND_DELAY_W-1:0] delay_cnt;
   logic                    delay_done;
   // low while the anti-message of a rollback pair is due
   logic                    second_half;
   phold_pkg::time_offset_t new_offset;
   phold_pkg::event_msg_t   new_msg;
   phold_pkg::event_msg_t   rbk_cancel_msg;
   phold_pkg::event_msg_t   rbk_regular_msg;
   phold_pkg::event_msg_t   first_msg;

   assign ready           = (state == phold_pkg::idle);
   assign clear           = (state == phold_pkg::idle);
   assign start_read      = (state == phold_pkg::read_hist);
   assign start_write     = (state == phold_pkg::write_hist);
   assign new_event_ready = (state == phold_pkg::wait_ack);
   assign gen_wr          = (state == phold_pkg::gen_evt) && !discard_cur;
   assign rbk_pop         = new_event_ready && ack && !rbk_empty && second_half;

   assign delay_done = (delay_cnt == rnd[`PHOLD_RND_DELAY_LSB +: `PHOLD_RND_DELAY_W]);

   // next event keeps at least the minimum gap
   assign new_offset = phold_pkg::time_offset_t'(`PHOLD_MIN_GAP) +
                       phold_pkg::time_offset_t'(rnd[`PHOLD_RND_STAMP_W-1:0]);

   assign new_msg = '{pad:       '0,
                      is_cancel: 1'b0,
                      target:    rnd[`PHOLD_RND_TARGET_LSB +: `PHOLD_LPID_W],
                      stamp:     cur.stamp + new_offset};

   // history keeps the event just run plus where its child went
   assign gen_entry = '{pad:       '0,
                        target:    new_msg.target,
                        offset:    new_offset,
                        is_cancel: cur.is_cancel,
                        stamp:     cur.stamp};

   assign rbk_cancel_msg = '{pad:       '0,
                             is_cancel: 1'b1,
                             target:    rbk_entry.target,
                             stamp:     rbk_entry.stamp + rbk_entry.offset};

   // straggled event sent back to this lp
   assign rbk_regular_msg = '{pad:       '0,
                              is_cancel: 1'b0,
                              target:    cur.target,
                              stamp:     rbk_entry.stamp};

   always_comb begin
      if (discard_cur)
         first_msg = cancel_valid ? cancel_msg : null_msg;
      else if (cur.is_cancel)
         first_msg = null_msg;
      else
         first_msg = new_msg;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= phold_pkg::idle;
         delay_cnt   <= '0;
         second_half <= 1'b0;
      end else begin
         case (state)
            phold_pkg::idle: begin
               second_half <= 1'b0;
               if (event_valid)
                  state <= phold_pkg::stall;
            end
            phold_pkg::stall: begin
               if (!stall)
                  state <= phold_pkg::read_hist;
            end
            phold_pkg::read_hist: begin
               if (done)
                  state <= phold_pkg::proc_delay;
            end
            phold_pkg::proc_delay: begin
               delay_cnt <= delay_cnt + 1'b1;
               if (delay_done) begin
                  delay_cnt <= '0;
                  state     <= phold_pkg::gen_evt;
               end
            end
            phold_pkg::gen_evt: begin
               state <= phold_pkg::write_hist;
            end
            phold_pkg::write_hist: begin
               if (done)
                  state <= phold_pkg::send_evt;
            end
            phold_pkg::send_evt: begin
               state <= phold_pkg::wait_ack;
            end
            phold_pkg::wait_ack: begin
               if (ack) begin
                  if (rbk_empty)
                     state <= phold_pkg::idle;
                  else
                     second_half <= !second_half;
               end
            end
            default: begin
               state <= phold_pkg::idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (ready && event_valid) begin
         cur <= event_in;
         gvt <= global_time;
         rnd <= random_in;
      end
      // new entry added unless the event is discarded
      if (state == phold_pkg::gen_evt)
         length <= discard_cur ? hist_count : hist_count + 1'b1;
      if (state == phold_pkg::send_evt)
         out_msg <= first_msg;
      else if (new_event_ready && ack && !rbk_empty)
         out_msg <= second_half ? rbk_regular_msg : rbk_cancel_msg;
   end

endmodule

`default_nettype wire

// ==== source/history_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

// first-word-fall-through buffer, dout shows the oldest entry
module history_fifo #(
   parameter int width = 32,
   parameter int depth = 16
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     clear,
   input  logic                     wr_en,
   input  logic [width-1:0]         din,
   input  logic                     rd_en,
   output logic [width-1:0]         dout,
   output logic                     empty,
   output logic [$clog2(depth)-1:0] count
);

   localparam int addr_w = $clog2(depth);

   logic [width-1:0]  mem [depth];
   logic [addr_w-1:0] wr_ptr;
   logic [addr_w-1:0] rd_ptr;
   // extra bit so a full buffer differs from an empty one
   logic [addr_w:0]   used;
   logic              do_rd;

   assign do_rd = rd_en && !empty;
   assign empty = (used == '0);
   assign count = used[addr_w-1:0];
   assign dout  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (reset || clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         used   <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + addr_w'(1);
         if (do_rd)
            rd_ptr <= rd_ptr + addr_w'(1);
         used <= used + (addr_w+1)'(wr_en) - (addr_w+1)'(do_rd);
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_ptr] <= din;
   end

endmodule

`default_nettype wire

// ==== source/history_filter.sv ====
`timescale 1ns/1ns
`default_nettype none

module history_filter (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   clear,
   input  logic                   rd_valid,
   input  phold_pkg::hist_entry_t rd_entry,
   input  phold_pkg::event_msg_t  cur,
   input  phold_pkg::sim_time_t   gvt,
   output logic                   keep_wr,
   output logic                   rollback_wr,
   output logic                   discard_cur,
   output logic                   cancel_valid,
   output phold_pkg::event_msg_t  cancel_msg
);

   logic expired;
   logic match;
   logic later;
   logic matched;
   logic take_match;

   // below gvt nothing can roll back to this entry any more
   assign expired = (rd_entry.stamp < gvt);

   // event and anti-message annihilate, only the first pair counts
   assign match = !matched &&
                  (rd_entry.is_cancel != cur.is_cancel) &&
                  (rd_entry.stamp == cur.stamp);

   // straggler, the stored event ran too early
   assign later = !cur.is_cancel && !rd_entry.is_cancel &&
                  (rd_entry.stamp > cur.stamp);

   assign take_match  = rd_valid && !expired && match;
   assign keep_wr     = rd_valid && !expired && !match && !later;
   assign rollback_wr = rd_valid && !expired && !match && later;
   assign discard_cur = matched;

   always_ff @(posedge clk) begin
      if (reset || clear) begin
         matched      <= 1'b0;
         cancel_valid <= 1'b0;
      end else if (take_match) begin
         matched      <= 1'b1;
         cancel_valid <= cur.is_cancel;
      end
   end

   // undo the event the cancelled entry had spawned
   always_ff @(posedge clk) begin
      if (take_match && cur.is_cancel) begin
         cancel_msg <= '{pad:       '0,
                         is_cancel: 1'b1,
                         target:    rd_entry.target,
                         stamp:     rd_entry.stamp + rd_entry.offset};
      end
   end

endmodule

`default_nettype wire

// ==== source/history_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module history_port (
   input  logic                   clk,
   input  logic                   reset,
   input  phold_pkg::lp_id_t      lp,
   input  logic                   start_read,
   input  logic                   start_write,
   input  phold_pkg::hist_cnt_t   length,
   output logic                   done,
   output logic                   rd_valid,
   output phold_pkg::hist_entry_t rd_entry,
   input  phold_pkg::hist_entry_t wr_entry,
   output logic                   wr_pop,
   output logic                   hist_rq,
   output logic                   hist_wr_en,
   output phold_pkg::hist_addr_t  hist_addr,
   output phold_pkg::hist_entry_t hist_wdata,
   input  phold_pkg::hist_entry_t hist_rdata,
   input  logic                   hist_grant
);

   phold_pkg::hist_state_t state;
   phold_pkg::hist_cnt_t   slot;
   phold_pkg::hist_cnt_t   len_q;
   logic                   writing;
   logic                   start;
   logic                   granted;
   logic                   last;

   assign start   = start_read || start_write;
   assign granted = hist_rq && hist_grant;
   assign last    = (slot == len_q - 1'b1);

   // request only while waiting, so it drops for a cycle after each grant
   assign hist_rq    = (state == phold_pkg::hist_wait);
   assign hist_wr_en = hist_rq && writing;
   assign hist_addr  = phold_pkg::hist_addr_t'({lp, slot});
   assign hist_wdata = wr_entry;
   assign wr_pop     = hist_wr_en && hist_grant;

   // empty burst finishes in the cycle it is asked for
   assign done = ((state == phold_pkg::hist_idle) && start && (length == '0)) ||
                 (granted && last);

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= phold_pkg::hist_idle;
         slot     <= '0;
         writing  <= 1'b0;
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= granted && !writing;
         case (state)
            phold_pkg::hist_idle: begin
               slot    <= '0;
               writing <= start_write;
               if (start && (length != '0))
                  state <= phold_pkg::hist_req;
            end
            phold_pkg::hist_req: begin
               state <= phold_pkg::hist_wait;
            end
            phold_pkg::hist_wait: begin
               if (hist_grant) begin
                  slot  <= slot + 1'b1;
                  state <= last ? phold_pkg::hist_idle : phold_pkg::hist_req;
               end
            end
            default: begin
               state <= phold_pkg::hist_idle;
            end
         endcase
      end
   end

   // burst length held for the whole burst, the write source drains meanwhile
   always_ff @(posedge clk) begin
      if (state == phold_pkg::hist_idle)
         len_q <= length;
      if (granted)
         rd_entry <= hist_rdata;
   end

endmodule

`default_nettype wire

// ==== source/phold_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "phold_params.svh"

module phold_core (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   event_valid,
   input  phold_pkg::event_msg_t  event_in,
   input  phold_pkg::sim_time_t   global_time,
   input  phold_pkg::rnd_t        random_in,
   input  logic                   stall,
   output logic                   ready,
   input  phold_pkg::hist_cnt_t   hist_size,
   output logic                   hist_rq,
   output logic                   hist_wr_en,
   output phold_pkg::hist_addr_t  hist_addr,
   output phold_pkg::hist_entry_t hist_wdata,
   input  phold_pkg::hist_entry_t hist_rdata,
   input  logic                   hist_grant,
   output logic                   new_event_ready,
   output phold_pkg::event_msg_t  out_msg,
   input  logic                   ack
);

   logic                   start_read;
   logic                   start_write;
   phold_pkg::hist_cnt_t   wr_len;
   phold_pkg::hist_cnt_t   burst_len;
   logic                   done;
   phold_pkg::event_msg_t  cur;
   phold_pkg::sim_time_t   gvt;
   logic                   discard_cur;
   logic                   cancel_valid;
   phold_pkg::event_msg_t  cancel_msg;
   phold_pkg::hist_cnt_t   hist_count;
   logic                   gen_wr;
   phold_pkg::hist_entry_t gen_entry;
   logic                   rbk_empty;
   phold_pkg::hist_entry_t rbk_entry;
   logic                   rbk_pop;
   logic                   clear;
   logic                   rd_valid;
   phold_pkg::hist_entry_t rd_entry;
   phold_pkg::hist_entry_t wr_entry;
   logic                   wr_pop;
   logic                   keep_wr;
   logic                   rollback_wr;
   phold_pkg::hist_entry_t hist_buf_din;

   // read burst covers the stored history, write burst the rebuilt one
   assign burst_len = start_read ? hist_size : wr_len;

   // kept entries first, generated entry appended after them
   assign hist_buf_din = gen_wr ? gen_entry : rd_entry;

   event_sequencer i_event_sequencer (
      .clk             (clk),
      .reset           (reset),
      .event_valid     (event_valid),
      .event_in        (event_in),
      .global_time     (global_time),
      .random_in       (random_in),
      .stall           (stall),
      .ready           (ready),
      .start_read      (start_read),
      .start_write     (start_write),
      .length          (wr_len),
      .done            (done),
      .cur             (cur),
      .gvt             (gvt),
      .discard_cur     (discard_cur),
      .cancel_valid    (cancel_valid),
      .cancel_msg      (cancel_msg),
      .hist_count      (hist_count),
      .gen_wr          (gen_wr),
      .gen_entry       (gen_entry),
      .rbk_empty       (rbk_empty),
      .rbk_entry       (rbk_entry),
      .rbk_pop         (rbk_pop),
      .clear           (clear),
      .new_event_ready (new_event_ready),
      .out_msg         (out_msg),
      .ack             (ack)
   );

   history_port i_history_port (
      .clk         (clk),
      .reset       (reset),
      .lp          (cur.target),
      .start_read  (start_read),
      .start_write (start_write),
      .length      (burst_len),
      .done        (done),
      .rd_valid    (rd_valid),
      .rd_entry    (rd_entry),
      .wr_entry    (wr_entry),
      .wr_pop      (wr_pop),
      .hist_rq     (hist_rq),
      .hist_wr_en  (hist_wr_en),
      .hist_addr   (hist_addr),
      .hist_wdata  (hist_wdata),
      .hist_rdata  (hist_rdata),
      .hist_grant  (hist_grant)
   );

   history_filter i_history_filter (
      .clk          (clk),
      .reset        (reset),
      .clear        (clear),
      .rd_valid     (rd_valid),
      .rd_entry     (rd_entry),
      .cur          (cur),
      .gvt          (gvt),
      .keep_wr      (keep_wr),
      .rollback_wr  (rollback_wr),
      .discard_cur  (discard_cur),
      .cancel_valid (cancel_valid),
      .cancel_msg   (cancel_msg)
   );

   history_fifo #(
      .width (`PHOLD_HIST_W),
      .depth (1 << `PHOLD_HIST_DEPTH_W)
   ) history_buf (
      .clk   (clk),
      .reset (reset),
      .clear (clear),
      .wr_en (keep_wr || gen_wr),
      .din   (hist_buf_din),
      .rd_en (wr_pop),
      .dout  (wr_entry),
      .empty (),
      .count (hist_count)
   );

   // stored events that ran ahead of the current one
   history_fifo #(
      .width (`PHOLD_HIST_W),
      .depth (1 << `PHOLD_HIST_DEPTH_W)
   ) rollback_buf (
      .clk   (clk),
      .reset (reset),
      .clear (clear),
      .wr_en (rollback_wr),
      .din   (rd_entry),
      .rd_en (rbk_pop),
      .dout  (rbk_entry),
      .empty (rbk_empty),
      .count ()
   );

endmodule

`default_nettype wire

// ==== source/phold_pkg.sv ====
`default_nettype none

`include "phold_params.svh"

package phold_pkg;

   typedef logic [`PHOLD_LPID_W-1:0]       lp_id_t;
   typedef logic [`PHOLD_TIME_W-1:0]       sim_time_t;
   typedef logic [`PHOLD_RND_W-1:0]        rnd_t;
   typedef logic [`PHOLD_HIST_ADDR_W-1:0]  hist_addr_t;
   typedef logic [`PHOLD_HIST_DEPTH_W-1:0] hist_cnt_t;
   typedef logic [`PHOLD_OFFSET_W-1:0]     time_offset_t;

   // event or anti-message as seen on the network
   typedef struct packed {
      logic [`PHOLD_MSG_W-`PHOLD_LPID_W-`PHOLD_TIME_W-2:0] pad;
      logic                                                is_cancel;
      lp_id_t                                              target;
      sim_time_t                                           stamp;
   } event_msg_t;

   // one processed event, with the offset and target of the event it spawned
   typedef struct packed {
      logic [`PHOLD_HIST_W-`PHOLD_LPID_W-`PHOLD_OFFSET_W-`PHOLD_TIME_W-2:0] pad;
      lp_id_t                                                                target;
      time_offset_t                                                          offset;
      logic                                                                  is_cancel;
      sim_time_t                                                             stamp;
   } hist_entry_t;

   typedef enum logic [2:0] {
      idle,
      stall,
      read_hist,
      proc_delay,
      gen_evt,
      write_hist,
      send_evt,
      wait_ack
   } core_state_t;

   typedef enum logic [1:0] {
      hist_idle,
      hist_req,
      hist_wait
   } hist_state_t;

endpackage

`default_nettype wire

// ==== verification/phold_core_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module phold_core_asserts (
   input logic                  clk,
   input logic                  reset,
   input logic                  ready,
   input logic                  hist_rq,
   input logic                  hist_wr_en,
   input logic                  new_event_ready,
   input phold_pkg::event_msg_t out_msg,
   input logic                  ack
);

   int unsigned fail_count = 0;

   // a write is always part of a request
   wr_needs_rq: assert property (@(posedge clk) disable iff (reset)
      hist_wr_en |-> hist_rq)
   else begin
      fail_count++;
      $error("hist_wr_en high without hist_rq");
   end

   msg_stable: assert property (@(posedge clk) disable iff (reset)
      new_event_ready && !ack |=> $stable(out_msg))
   else begin
      fail_count++;
      $error("out_msg changed without ack");
   end

   ready_excl: assert property (@(posedge clk) disable iff (reset)
      !(ready && new_event_ready))
   else begin
      fail_count++;
      $error("ready and new_event_ready both high");
   end

   // no memory traffic between events
   idle_quiet: assert property (@(posedge clk) disable iff (reset)
      ready |-> !hist_rq)
   else begin
      fail_count++;
      $error("hist_rq high while ready");
   end

endmodule

bind phold_core phold_core_asserts i_phold_core_asserts (
   .clk             (clk),
   .reset           (reset),
   .ready           (ready),
   .hist_rq         (hist_rq),
   .hist_wr_en      (hist_wr_en),
   .new_event_ready (new_event_ready),
   .out_msg         (out_msg),
   .ack             (ack)
);

`default_nettype wire

// ==== verification/phold_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "phold_params.svh"

module phold_core_tb;

   localparam int num_events = 10;
   localparam int max_cycles = num_events * 200;

   logic                   clk = 1'b0;
   logic                   reset;
   logic                   event_valid;
   phold_pkg::event_msg_t  event_in;
   phold_pkg::sim_time_t   global_time;
   phold_pkg::rnd_t        random_in;
   logic                   stall;
   logic                   ready;
   phold_pkg::hist_cnt_t   hist_size;
   logic                   hist_rq;
   logic                   hist_wr_en;
   phold_pkg::hist_addr_t  hist_addr;
   phold_pkg::hist_entry_t hist_wdata;
   phold_pkg::hist_entry_t hist_rdata;
   logic                   hist_grant;
   logic                   new_event_ready;
   phold_pkg::event_msg_t  out_msg;
   logic                   ack;

   // history memory model, sixteen slots per lp
   phold_pkg::hist_entry_t mem [256];
   phold_pkg::hist_cnt_t   counts [8];
   phold_pkg::lp_id_t      cur_lp;
   int                     grant_wait = 0;
   int                     ack_wait = 0;
   int                     wr_grants = 0;
   bit                     slow = 1'b0;
   int                     cycles = 0;
   int                     checks = 0;
   int                     errors = 0;
   string                  test_name = "reset";
   phold_pkg::event_msg_t  exp_msgs [$];
   phold_pkg::hist_entry_t exp_hist [$];

   assign hist_size = counts[cur_lp];

   always #10 clk = ~clk;

   phold_core i_phold_core (.*);

   function automatic phold_pkg::hist_addr_t slot_addr(phold_pkg::lp_id_t lp, int slot);
      return phold_pkg::hist_addr_t'((int'(lp) << `PHOLD_HIST_DEPTH_W) + slot);
   endfunction

   function automatic phold_pkg::event_msg_t make_msg(logic is_cancel,
                                                      phold_pkg::lp_id_t target,
                                                      phold_pkg::sim_time_t stamp);
      phold_pkg::event_msg_t m;
      m = '0;
      m.is_cancel = is_cancel;
      m.target    = target;
      m.stamp     = stamp;
      return m;
   endfunction

   function automatic phold_pkg::hist_entry_t make_entry(phold_pkg::lp_id_t target,
                                                         phold_pkg::time_offset_t offset,
                                                         logic is_cancel,
                                                         phold_pkg::sim_time_t stamp);
      phold_pkg::hist_entry_t e;
      e = '0;
      e.target    = target;
      e.offset    = offset;
      e.is_cancel = is_cancel;
      e.stamp     = stamp;
      return e;
   endfunction

   task automatic check_word(string name, logic [31:0] expected, logic [31:0] actual);
      checks++;
      assert (actual === expected)
      else begin
         errors++;
         $display("FAIL %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic store_entry(phold_pkg::lp_id_t lp, phold_pkg::hist_entry_t e);
      mem[slot_addr(lp, counts[lp])] = e;
      counts[lp] = counts[lp] + 1'b1;
   endtask

   // expected messages and history for one event, from the memory image
   task automatic build_expected(phold_pkg::event_msg_t ev, phold_pkg::sim_time_t gvt,
                                 phold_pkg::rnd_t rnd);
      phold_pkg::hist_entry_t  e;
      phold_pkg::hist_entry_t  rbk [$];
      phold_pkg::event_msg_t   first;
      phold_pkg::time_offset_t offset;
      phold_pkg::lp_id_t       target;
      logic                    matched;
      exp_msgs.delete();
      exp_hist.delete();
      matched = 1'b0;
      first   = make_msg(1'b1, '0, '0);
      offset  = phold_pkg::time_offset_t'(`PHOLD_MIN_GAP + rnd[5:0]);
      target  = rnd[10:8];
      for (int i = 0; i < counts[ev.target]; i++) begin
         e = mem[slot_addr(ev.target, i)];
         if (e.stamp >= gvt) begin
            if (!matched && (e.is_cancel != ev.is_cancel) && (e.stamp == ev.stamp)) begin
               matched = 1'b1;
               if (ev.is_cancel)
                  first = make_msg(1'b1, e.target, e.stamp + e.offset);
            end else if (!ev.is_cancel && !e.is_cancel && (e.stamp > ev.stamp)) begin
               rbk.push_back(e);
            end else begin
               exp_hist.push_back(e);
            end
         end
      end
      if (!matched) begin
         exp_hist.push_back(make_entry(target, offset, ev.is_cancel, ev.stamp));
         if (!ev.is_cancel)
            first = make_msg(1'b0, target, ev.stamp + offset);
      end
      exp_msgs.push_back(first);
      foreach (rbk[i]) begin
         exp_msgs.push_back(make_msg(1'b1, rbk[i].target, rbk[i].stamp + rbk[i].offset));
         exp_msgs.push_back(make_msg(1'b0, ev.target, rbk[i].stamp));
      end
   endtask

   // starts and ends 2 ns after a rising edge with ready high
   task automatic run_event(string name, phold_pkg::event_msg_t ev, phold_pkg::sim_time_t gvt);
      phold_pkg::rnd_t rnd;
      int              stall_cycles;
      rnd          = phold_pkg::rnd_t'($urandom);
      stall_cycles = slow ? $urandom_range(8, 1) : 0;
      build_expected(ev, gvt, rnd);
      test_name   = name;
      cur_lp      = ev.target;
      wr_grants   = 0;
      event_valid = 1'b1;
      event_in    = ev;
      global_time = gvt;
      random_in   = rnd;
      stall       = slow;
      @(posedge clk);
      #2;
      event_valid = 1'b0;
      // the core has to run from what it latched
      event_in    = phold_pkg::event_msg_t'($urandom);
      global_time = phold_pkg::sim_time_t'($urandom);
      random_in   = phold_pkg::rnd_t'($urandom);
      repeat (stall_cycles) begin
         @(posedge clk);
         #2;
      end
      stall = 1'b0;
      while (!ready) begin
         @(posedge clk);
         #2;
      end
      if (exp_msgs.size() != 0) begin
         errors++;
         $display("%s: %0d expected messages were never sent", name, exp_msgs.size());
      end
      counts[ev.target] = phold_pkg::hist_cnt_t'(wr_grants);
      check_word({name, " count"}, exp_hist.size(), counts[ev.target]);
      foreach (exp_hist[i])
         check_word($sformatf("%s slot %0d", name, i), exp_hist[i],
                    mem[slot_addr(ev.target, i)]);
   endtask

   task automatic run_scenarios(string tag);
      counts[1] = '0;
      run_event({tag, "empty lp"}, make_msg(1'b0, 3'd1, 16'd100), 16'd50);

      counts[2] = '0;
      store_entry(3'd2, make_entry(3'd1, 8'd11, 1'b0, 16'd20));
      store_entry(3'd2, make_entry(3'd3, 8'd20, 1'b0, 16'd60));
      store_entry(3'd2, make_entry(3'd5, 8'd30, 1'b1, 16'd30));
      store_entry(3'd2, make_entry(3'd0, 8'd12, 1'b0, 16'd70));
      run_event({tag, "expired"}, make_msg(1'b0, 3'd2, 16'd200), 16'd50);

      counts[3] = '0;
      store_entry(3'd3, make_entry(3'd2, 8'd14, 1'b0, 16'd150));
      store_entry(3'd3, make_entry(3'd5, 8'd20, 1'b0, 16'd300));
      store_entry(3'd3, make_entry(3'd6, 8'd33, 1'b0, 16'd320));
      run_event({tag, "rollback"}, make_msg(1'b0, 3'd3, 16'd200), 16'd100);

      counts[4] = '0;
      store_entry(3'd4, make_entry(3'd6, 8'd15, 1'b0, 16'd400));
      store_entry(3'd4, make_entry(3'd2, 8'd12, 1'b0, 16'd420));
      run_event({tag, "anti match"}, make_msg(1'b1, 3'd4, 16'd400), 16'd100);

      counts[5] = '0;
      store_entry(3'd5, make_entry(3'd1, 8'd10, 1'b0, 16'd500));
      run_event({tag, "anti no match"}, make_msg(1'b1, 3'd5, 16'd510), 16'd100);
   endtask

   // memory answers each request after a random wait
   always begin
      @(posedge clk);
      #2;
      if (hist_grant) begin
         hist_grant = 1'b0;
      end else if (hist_rq) begin
         if (grant_wait > 0) begin
            grant_wait--;
         end else begin
            hist_grant = 1'b1;
            hist_rdata = mem[hist_addr];
            if (hist_wr_en) begin
               mem[hist_addr] = hist_wdata;
               wr_grants++;
            end
            grant_wait = slow ? $urandom_range(6, 1) : $urandom_range(1, 0);
         end
      end
   end

   // message sink, checks each message before it is acknowledged
   always begin
      @(posedge clk);
      #2;
      if (new_event_ready && !ack) begin
         if (ack_wait > 0) begin
            ack_wait--;
         end else begin
            if (exp_msgs.size() == 0) begin
               errors++;
               $display("%s: unexpected message %h", test_name, out_msg);
            end else begin
               check_word({test_name, " message"}, exp_msgs.pop_front(), out_msg);
            end
            ack      = 1'b1;
            ack_wait = slow ? $urandom_range(4, 0) : 0;
         end
      end else begin
         ack = 1'b0;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles) begin
         $display("timeout after %0d cycles in %s, the core never finished", cycles, test_name);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   initial begin
      void'($urandom(32'h2c96_5b99));
      reset       = 1'b1;
      event_valid = 1'b0;
      event_in    = '0;
      global_time = '0;
      random_in   = '0;
      stall       = 1'b0;
      hist_rdata  = '0;
      hist_grant  = 1'b0;
      ack         = 1'b0;
      cur_lp      = '0;
      foreach (counts[i])
         counts[i] = '0;
      foreach (mem[a])
         mem[a] = {a[7:0], ~a[7:0], a[7:0] ^ 8'h5a, ~(a[7:0] ^ 8'ha5)};
      repeat (8) @(posedge clk);
      #2;
      reset = 1'b0;
      slow  = 1'b0;
      run_scenarios("");
      slow = 1'b1;
      run_scenarios("slow ");
      $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
               i_phold_core.i_phold_core_asserts.fail_count);
      if (errors == 0 && i_phold_core.i_phold_core_asserts.fail_count == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
source/phold_pkg.sv
source/history_fifo.sv
source/history_port.sv
source/history_filter.sv
source/event_sequencer.sv
source/phold_core.sv
verification/phold_core_asserts.sv
verification/phold_core_tb.sv
